/* verilog/blackjack_params.svh */
// game limits shared by rtl and tb; the tap mask in card_lfsr assumes BJ_SEED_W is 16
`ifndef BLACKJACK_PARAMS_SVH
`define BLACKJACK_PARAMS_SVH

// ------------------------------
// hand limits
// ------------------------------

// cards one hand may hold
`define BJ_MAX_CARDS 9

// totals above this are a bust
`define BJ_BUST_LIMIT 21

// dealer keeps drawing below this total
`define BJ_DEALER_STAND 17

// ------------------------------
// card source
// ------------------------------

`define BJ_SEED_W 16

// loaded instead of an all-zero seed, which would lock the register
`define BJ_DEFAULT_SEED 16'hACE1

`endif

/* verilog/blackjack_pkg.sv */
// types for the round controller; widths assume at most 9 cards of at most 11 points each
package blackjack_pkg;

    typedef logic [3:0] card_t;  // rank 1..13
    typedef logic [6:0] total_t; // hand total, raw or soft-adjusted
    typedef logic [3:0] count_t; // cards in a hand

    // round outcome as seen on the top-level ports
    typedef enum logic [1:0] {
        result_none   = 2'd0,
        result_player = 2'd1,
        result_dealer = 2'd2,
        result_draw   = 2'd3
    } result_t;

    typedef enum logic [3:0] {
        st_idle         = 4'd0,
        st_deal_p1      = 4'd1,
        st_deal_d1      = 4'd2,
        st_deal_p2      = 4'd3,
        st_player_turn  = 4'd4,
        st_player_draw  = 4'd5,
        st_player_check = 4'd6,
        st_dealer_draw  = 4'd7,
        st_dealer_check = 4'd8,
        st_compare      = 4'd9,
        st_done         = 4'd10
    } game_state_t;

endpackage

/* verilog/card_lfsr.sv */
// cards are not drawn from a real deck: ranks repeat freely and 1..3 are slightly more likely
`timescale 1ns/1ps
`include "blackjack_params.svh"

module card_lfsr import blackjack_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,  // reseed at round start
    input  logic [`BJ_SEED_W-1:0] seed,
    input  logic                  step,  // one draw taken this cycle
    output card_t                 card
);

    // right-shifting galois form, 16-bit maximal length
    localparam logic [`BJ_SEED_W-1:0] tap_mask = 16'hB400;

    logic [`BJ_SEED_W-1:0] lfsr_q;
    logic [`BJ_SEED_W-1:0] lfsr_nxt;
    logic [`BJ_SEED_W-1:0] seed_eff;
    logic [3:0]            low_bits;

    // ------------------------------
    // register update
    // ------------------------------

    assign seed_eff = (seed == '0) ? `BJ_DEFAULT_SEED : seed;
    assign lfsr_nxt = (lfsr_q >> 1) ^ (lfsr_q[0] ? tap_mask : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= `BJ_DEFAULT_SEED;
        end else if (load) begin
            lfsr_q <= seed_eff; // load beats step
        end else if (step) begin
            lfsr_q <= lfsr_nxt;
        end
    end

    // ------------------------------
    // rank mapping
    // ------------------------------

    assign low_bits = lfsr_q[3:0];

    // 0..12 -> 1..13, 13..15 fold back onto 1..3
    always_comb begin
        if (low_bits < 4'd13) begin
            card = card_t'(low_bits + 4'd1);
        end else begin
            card = card_t'(low_bits - 4'd12);
        end
    end

endmodule

/* verilog/hand_scorer.sv */
// one hand only; cards offered while full are dropped, and clear wins over add in the same cycle
`timescale 1ns/1ps
`include "blackjack_params.svh"

module hand_scorer import blackjack_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,  // new round
    input  logic   add,    // card strobe for this hand
    input  card_t  card,
    output total_t total,
    output count_t count,
    output logic   full
);

    localparam total_t ace_bonus = total_t'(10); // ace raised from 1 to 11

    total_t raw_sum;   // aces as 1, faces as 10
    total_t card_pts;
    total_t raised_sum;
    logic   has_ace;
    logic   is_ace;

    // ------------------------------
    // card points
    // ------------------------------

    assign is_ace = (card == card_t'(1));

    always_comb begin
        if (card > card_t'(10)) begin
            card_pts = total_t'(10); // jack, queen, king
        end else begin
            card_pts = total_t'(card);
        end
    end

    // ------------------------------
    // accumulation
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            raw_sum <= '0;
            has_ace <= 1'b0;
            count   <= '0;
        end else if (add && !full) begin
            raw_sum <= raw_sum + card_pts;
            count   <= count + count_t'(1);
            if (is_ace) begin
                has_ace <= 1'b1;
            end
        end
    end

    // ------------------------------
    // soft ace adjust
    // ------------------------------

    // only one ace can ever count 11 without busting
    assign raised_sum = raw_sum + ace_bonus;

    always_comb begin
        if (has_ace && (raised_sum <= total_t'(`BJ_BUST_LIMIT))) begin
            total = raised_sum;
        end else begin
            total = raw_sum;
        end
    end

    assign full = (count >= count_t'(`BJ_MAX_CARDS));

endmodule

/* verilog/game_fsm.sv */
// one player against an automatic dealer; pulses outside the accepting states are dropped
`timescale 1ns/1ps
`include "blackjack_params.svh"

module game_fsm import blackjack_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    hit,
    input  logic    stand,
    input  total_t  player_total,
    input  total_t  dealer_total,
    input  logic    player_full,
    input  logic    dealer_full,
    output logic    clear_hands,
    output logic    reseed,
    output logic    draw,
    output logic    to_dealer,
    output logic    player_turn,
    output result_t result,
    output logic    result_valid
);

    game_state_t state;
    game_state_t state_nxt;
    result_t     result_nxt;
    result_t     final_result;
    logic        result_valid_nxt;
    logic        round_start;
    logic        player_bust;
    logic        dealer_bust;
    logic        dealer_wants;

    // ------------------------------
    // status from the hands
    // ------------------------------

    assign round_start  = start && ((state == st_idle) || (state == st_done));
    assign player_bust  = (player_total > total_t'(`BJ_BUST_LIMIT));
    assign dealer_bust  = (dealer_total > total_t'(`BJ_BUST_LIMIT));
    assign dealer_wants = (dealer_total < total_t'(`BJ_DEALER_STAND)) && !dealer_full;

    // outcome after the dealer has finished
    always_comb begin
        if (dealer_bust) begin
            final_result = result_player;
        end else if (player_total > dealer_total) begin
            final_result = result_player;
        end else if (player_total == dealer_total) begin
            final_result = result_draw;
        end else begin
            final_result = result_dealer;
        end
    end

    // ------------------------------
    // state and result registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            result       <= result_none;
            result_valid <= 1'b0;
        end else begin
            state        <= state_nxt;
            result       <= result_nxt;
            result_valid <= result_valid_nxt;
        end
    end

    // ------------------------------
    // next state
    // ------------------------------

    always_comb begin
        state_nxt        = state;
        result_nxt       = result;
        result_valid_nxt = result_valid;
        case (state)
            st_idle, st_done: begin
                if (start) begin
                    state_nxt        = st_deal_p1;
                    result_nxt       = result_none; // old result dropped here
                    result_valid_nxt = 1'b0;
                end
            end
            st_deal_p1: state_nxt = st_deal_d1;
            st_deal_d1: state_nxt = st_deal_p2;
            st_deal_p2: state_nxt = st_player_turn;
            st_player_turn: begin
                if (hit && !player_full) begin // hit wins a tie with stand
                    state_nxt = st_player_draw;
                end else if (stand) begin
                    state_nxt = st_dealer_draw;
                end
            end
            st_player_draw: state_nxt = st_player_check;
            st_player_check: begin
                // total already includes the card from the draw state
                if (player_bust) begin
                    state_nxt        = st_done;
                    result_nxt       = result_dealer;
                    result_valid_nxt = 1'b1;
                end else begin
                    state_nxt = st_player_turn;
                end
            end
            st_dealer_draw: begin
                if (dealer_wants) begin
                    state_nxt = st_dealer_check;
                end else begin
                    state_nxt = st_compare;
                end
            end
            st_dealer_check: begin
                if (dealer_wants) begin
                    state_nxt = st_dealer_draw;
                end else begin
                    state_nxt = st_compare; // stands or busted
                end
            end
            st_compare: begin
                state_nxt        = st_done;
                result_nxt       = final_result;
                result_valid_nxt = 1'b1;
            end
            default: state_nxt = st_idle;
        endcase
    end

    // ------------------------------
    // card strobes
    // ------------------------------

    always_comb begin
        draw      = 1'b0;
        to_dealer = 1'b0;
        case (state)
            st_deal_p1, st_deal_p2, st_player_draw: begin
                draw = 1'b1;
            end
            st_deal_d1: begin
                draw      = 1'b1;
                to_dealer = 1'b1;
            end
            st_dealer_draw: begin
                draw      = dealer_wants; // may fall straight through to compare
                to_dealer = dealer_wants;
            end
            default: begin
            end
        endcase
    end

    assign player_turn = (state == st_player_turn);
    assign clear_hands = round_start;
    assign reseed      = round_start; // same edge as the hand clear

endmodule

/* verilog/blackjack_top.sv */
// start/hit/stand are single-cycle pulses with no handshake; card_valid is the only card strobe
`timescale 1ns/1ps
`include "blackjack_params.svh"

module blackjack_top import blackjack_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  hit,
    input  logic                  stand,
    input  logic [`BJ_SEED_W-1:0] seed,
    output logic                  card_valid,
    output card_t                 card_value,
    output logic                  card_to_dealer,
    output total_t                player_total,
    output total_t                dealer_total,
    output logic                  player_turn,
    output result_t               result,
    output logic                  result_valid
);

    logic  clear_hands;
    logic  reseed;
    logic  draw;
    logic  to_dealer;
    logic  player_full;
    logic  dealer_full;
    logic  player_add;
    logic  dealer_add;
    card_t card;

    // ------------------------------
    // card routing
    // ------------------------------

    assign player_add     = draw && !to_dealer;
    assign dealer_add     = draw && to_dealer;
    assign card_valid     = draw;
    assign card_value     = card;
    assign card_to_dealer = to_dealer;

    card_lfsr lfsr_i (
        .clk  (clk),
        .rst  (rst),
        .load (reseed),
        .seed (seed),
        .step (draw),   // advances on every card dealt
        .card (card)
    );

    hand_scorer player_hand_i (
        .clk   (clk),
        .rst   (rst),
        .clear (clear_hands),
        .add   (player_add),
        .card  (card),
        .total (player_total),
        .count (),
        .full  (player_full)
    );

    hand_scorer dealer_hand_i (
        .clk   (clk),
        .rst   (rst),
        .clear (clear_hands),
        .add   (dealer_add),
        .card  (card),
        .total (dealer_total),
        .count (),
        .full  (dealer_full)
    );

    game_fsm fsm_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .hit          (hit),
        .stand        (stand),
        .player_total (player_total),
        .dealer_total (dealer_total),
        .player_full  (player_full),
        .dealer_full  (dealer_full),
        .clear_hands  (clear_hands),
        .reseed       (reseed),
        .draw         (draw),
        .to_dealer    (to_dealer),
        .player_turn  (player_turn),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* testbench/blackjack_sva.sv */
// bound into game_fsm; properties are only checked while rst is low
`timescale 1ns/1ps

module blackjack_sva import blackjack_pkg::*; (
    input logic        clk,
    input logic        rst,
    input game_state_t state,
    input logic        draw,
    input logic        reseed,
    input logic        player_turn,
    input result_t     result,
    input logic        result_valid
);

    // ------------------------------
    // strobes
    // ------------------------------

    // no card while waiting for a round
    a_no_draw_idle: assert property (@(posedge clk) disable iff (rst)
        ((state == st_idle) || (state == st_done)) |-> !draw)
        else $error("draw raised in idle or done");

    a_turn_no_draw: assert property (@(posedge clk) disable iff (rst)
        !(player_turn && draw))
        else $error("draw raised during the player turn");

    a_reseed_pulse: assert property (@(posedge clk) disable iff (rst)
        reseed |=> !reseed) // one cycle only
        else $error("reseed held longer than one cycle");

    // ------------------------------
    // result
    // ------------------------------

    a_result_set: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> (result != result_none))
        else $error("result_valid with an empty result");

endmodule

/* testbench/blackjack_tb.sv */
// run from the project root so the pattern path resolves; stops at the first mismatch
`timescale 1ns/1ps
`include "blackjack_params.svh"

module blackjack_tb import blackjack_pkg::*; ();

    localparam int wait_limit  = 200; // cycles allowed per wait loop
    localparam int wait_card   = 0;
    localparam int wait_turn   = 1;
    localparam int wait_result = 2;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  hit;
    logic                  stand;
    logic [`BJ_SEED_W-1:0] seed;
    logic                  card_valid;
    card_t                 card_value;
    logic                  card_to_dealer;
    total_t                player_total;
    total_t                dealer_total;
    logic                  player_turn;
    result_t               result;
    logic                  result_valid;

    // reference hands rebuilt from the card_valid beats
    int p_raw;
    int d_raw;
    bit p_ace;
    bit d_ace;
    bit monitor_on;
    int round_cards[64];
    int round_n;
    int prev_cards[64];
    int prev_n;
    int last_seed;
    int rand_seed;

    blackjack_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .hit            (hit),
        .stand          (stand),
        .seed           (seed),
        .card_valid     (card_valid),
        .card_value     (card_value),
        .card_to_dealer (card_to_dealer),
        .player_total   (player_total),
        .dealer_total   (dealer_total),
        .player_turn    (player_turn),
        .result         (result),
        .result_valid   (result_valid)
    );

    bind game_fsm blackjack_sva sva_i (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .draw         (draw),
        .reseed       (reseed),
        .player_turn  (player_turn),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input int got, input int expected, input string what);
        string msg;
        if (got != expected) begin
            msg = $sformatf("FAIL at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
            stop_run(msg);
        end
    endtask

    function automatic int card_points(input int rank);
        if (rank > 10) begin
            return 10; // faces
        end
        return rank;
    endfunction

    // one ace counts 11 when that keeps the hand at or below 21
    function automatic int hand_total(input int raw, input bit ace);
        if (ace && (raw + 10 <= `BJ_BUST_LIMIT)) begin
            return raw + 10;
        end
        return raw;
    endfunction

    function automatic bit event_seen(input int kind);
        case (kind)
            wait_card: return card_valid;
            wait_turn: return player_turn || result_valid;
            default:   return result_valid;
        endcase
    endfunction

    task automatic wait_for(input int kind, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!event_seen(kind)) begin
            if (cycles >= wait_limit) begin
                stop_run({"timeout waiting for ", what});
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic press(input logic hit_v, input logic stand_v);
        @(posedge clk);
        hit   <= hit_v;
        stand <= stand_v;
        @(posedge clk);
        hit   <= 1'b0;
        stand <= 1'b0;
    endtask

    // ------------------------------
    // card trace monitor
    // ------------------------------

    always @(negedge clk) begin
        int rank;
        if (monitor_on) begin
            check_equal(int'(player_total), hand_total(p_raw, p_ace), "player total vs trace");
            check_equal(int'(dealer_total), hand_total(d_raw, d_ace), "dealer total vs trace");
            if (start) begin // hands clear on the coming edge
                p_raw   = 0;
                d_raw   = 0;
                p_ace   = 1'b0;
                d_ace   = 1'b0;
                round_n = 0;
            end
            if (card_valid) begin
                rank = int'(card_value);
                check_equal(int'((rank >= 1) && (rank <= 13)), 1, "card rank in 1..13");
                if (card_to_dealer) begin
                    check_equal(int'(hand_total(d_raw, d_ace) < `BJ_DEALER_STAND), 1,
                                "dealer draws only below its stand total");
                    check_equal(int'(hand_total(p_raw, p_ace) <= `BJ_BUST_LIMIT), 1,
                                "no dealer card after a player bust");
                    d_raw = d_raw + card_points(rank);
                    d_ace = d_ace || (rank == 1);
                end else begin
                    p_raw = p_raw + card_points(rank);
                    p_ace = p_ace || (rank == 1);
                end
                if (round_n < 64) begin
                    round_cards[round_n] = rank;
                    round_n++;
                end
            end
        end
    end

    // ------------------------------
    // rounds
    // ------------------------------

    task automatic ignore_outside_turn();
        int held_n;
        int held_result;
        held_n      = round_n;
        held_result = int'(result);
        press(1'b1, 1'b0);
        press(1'b0, 1'b1);
        press(1'b1, 1'b1);
        @(negedge clk);
        @(negedge clk);
        check_equal(round_n, held_n, "no card from hit or stand after the round");
        check_equal(int'(result_valid), 1, "result still valid");
        check_equal(int'(result), held_result, "result held after the round");
    endtask

    task automatic play_round(input logic [`BJ_SEED_W-1:0] round_seed, input int hits,
                              input int exp_result, input int exp_player, input int exp_dealer,
                              input bit long_start);
        int i;
        int gap;
        int both;
        int eff_seed;
        bit same_seed;
        eff_seed = int'(round_seed);
        if (eff_seed == 0) begin
            eff_seed = int'(`BJ_DEFAULT_SEED);
        end
        for (i = 0; i < round_n; i++) begin
            prev_cards[i] = round_cards[i];
        end
        prev_n    = round_n;
        same_seed = (prev_n > 0) && (eff_seed == last_seed);

        @(posedge clk);
        seed  <= round_seed;
        start <= 1'b1;
        @(posedge clk);
        start <= long_start; // a start held into the deal must be dropped
        // deal is player, dealer, player on back-to-back cycles
        wait_for(wait_card, "first dealt card");
        check_equal(int'(card_to_dealer), 0, "first card to player");
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_equal(int'(card_valid && card_to_dealer), 1, "second card to dealer");
        @(negedge clk);
        check_equal(int'(card_valid && !card_to_dealer), 1, "third card to player");
        @(negedge clk);
        check_equal(int'(player_turn && !card_valid), 1, "player turn right after deal");

        for (i = 0; (i < hits) && !result_valid; i++) begin
            gap = {$random(rand_seed)} % 4;
            repeat (gap) @(posedge clk);
            both = $random(rand_seed);
            press(1'b1, both[0]); // a stand in the same cycle must lose
            wait_for(wait_turn, "player turn after hit");
        end
        if (!result_valid) begin
            press(1'b0, 1'b1);
            wait_for(wait_result, "result after stand");
        end

        check_equal(int'(result), exp_result, "round result");
        check_equal(int'(player_total), exp_player, "final player total");
        check_equal(int'(dealer_total), exp_dealer, "final dealer total");
        if (same_seed) begin
            for (i = 0; (i < round_n) && (i < prev_n); i++) begin
                check_equal(round_cards[i], prev_cards[i], "card sequence for a repeated seed");
            end
        end
        last_seed = eff_seed;
        ignore_outside_turn();
    endtask

    initial begin
        string                 line;
        int                    fd;
        int                    code;
        int                    fields;
        int                    rounds;
        logic [`BJ_SEED_W-1:0] pat_seed;
        int                    pat_hits;
        int                    pat_result;
        int                    pat_player;
        int                    pat_dealer;
        rst        = 1'b1;
        start      = 1'b0;
        hit        = 1'b0;
        stand      = 1'b0;
        seed       = '0;
        p_raw      = 0;
        d_raw      = 0;
        p_ace      = 1'b0;
        d_ace      = 1'b0;
        round_n    = 0;
        prev_n     = 0;
        last_seed  = 0;
        rounds     = 0;
        monitor_on = 1'b0;
        rand_seed  = 3557;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(int'(player_turn), 0, "player_turn after reset");
        check_equal(int'(result_valid), 0, "result_valid after reset");
        check_equal(int'(result), int'(result_none), "result after reset");
        monitor_on = 1'b1;

        fd = $fopen("testbench/blackjack_patterns.txt", "r");
        if (fd == 0) begin
            stop_run("could not open testbench/blackjack_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if ((code > 0) && (line.substr(0, 0) != "#")) begin
                fields = $sscanf(line, "%h %d %d %d %d", pat_seed, pat_hits, pat_result,
                                 pat_player, pat_dealer);
                if (fields == 5) begin
                    play_round(pat_seed, pat_hits, pat_result, pat_player, pat_dealer,
                               rounds[0]);
                    rounds++;
                end
            end
        end
        $fclose(fd);
        if (rounds == 0) begin
            stop_run("pattern file held no rounds");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* testbench/blackjack_patterns.txt */
# seed(hex) hits result(1 player, 2 dealer, 3 draw) player_total dealer_total
# seed 0000 is replaced by the default seed, so ACE1 repeats its cards
1234 0 2 16 17
1234 1 1 13 25
1234 3 3 19 19
1234 4 2 28 10
0000 0 2 11 21
0000 1 3 21 21
ACE1 0 2 11 21
BEEF 1 2 14 18
BEEF 2 1 16 26
356C 0 1 20 18

/* blackjack.f */
+incdir+verilog
verilog/blackjack_pkg.sv
verilog/card_lfsr.sv
verilog/hand_scorer.sv
verilog/game_fsm.sv
verilog/blackjack_top.sv
testbench/blackjack_sva.sv
testbench/blackjack_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f blackjack.f --top-module blackjack_tb -o sim_bin
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_bin 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
